//--- files.f
+incdir+tests
source/clk_lane_pkg.sv
source/interval_timer.sv
source/lp_lane_fsm.sv
source/hs_clk_fsm.sv
source/clk_lane_tx_top.sv
tests/clk_lane_tx_tb.sv

//--- source/clk_lane_pkg.sv
/* Interval constants, count types and the LP line / state encodings
   shared by the D-PHY clock-lane transmitter */

package clk_lane_pkg;

  // **********************************************************************
  // Interval constants, in txddrclkhs_q cycles
  // **********************************************************************
  localparam int DDR_CNT_SCALE   = 4;    // Every lane count is in units of four cycles
  localparam int CLK_PRE_CYCLES  = 8;    // HS clock toggles seen before sot rises
  localparam int CLK_POST_CYCLES = 32;   // Rising eot to the earliest trail start

  // Count types
  typedef logic [7:0] lane_cnt_t;        // Raw count as it arrives on cln_cnt_*
  typedef logic [9:0] cycle_cnt_t;       // Scaled count, up to 4 x 255

  // **********************************************************************
  // Encodings
  // **********************************************************************
  // LP line pair, P line in the upper bit
  typedef enum logic [1:0] {
    LP_00 = 2'b00,                       // Bridge / ULPS
    LP_01 = 2'b01,                       // HS request
    LP_10 = 2'b10,                       // ULPS request, Mark-1
    LP_11 = 2'b11                        // Stop
  } lp_line_e;

  // Low-power lane control
  typedef enum logic [2:0] {
    LP_STOP      = 3'd0,
    LP_HS_RQST   = 3'd1,                 // LP-01 for the LPX count
    LP_HS_PRPR   = 3'd2,                 // LP-00 for the prepare count
    LP_HS_ACTIVE = 3'd3,                 // HS driver owns the lane
    LP_HS_EXIT   = 3'd4,                 // LP-11 for the exit count
    LP_ULPS_RQST = 3'd5,
    LP_ULPS      = 3'd6,
    LP_ULPS_EXIT = 3'd7
  } lp_state_e;

  // High-speed clock generation
  typedef enum logic [1:0] {
    HS_IDLE   = 2'd0,
    HS_ZERO   = 2'd1,                    // Differential zero before toggling
    HS_TOGGLE = 2'd2,                    // Clock running
    HS_TRAIL  = 2'd3                     // Zero again before LP takes over
  } hs_state_e;

endpackage

//--- source/clk_lane_tx_top.sv
/* D-PHY clock-lane transmitter top, LP and HS state machines */
`timescale 1ns/100ps

module clk_lane_tx_top
  import clk_lane_pkg::*;
(
  input  logic       txddrclkhs_q,       // HS quadrature clock
  input  logic       txddr_q_rst_n,      // Sync reset, active high
  input  logic       txrequesths_clk,    // PPI HS clock request
  input  logic       txulpsclk,          // PPI ULPS request
  input  logic       txulpsexit_clk,     // PPI ULPS exit
  input  logic       eot,                // From the data lanes
  input  lane_cnt_t  cln_cnt_lpx,
  input  lane_cnt_t  cln_cnt_hs_prep,
  input  lane_cnt_t  cln_cnt_hs_zero,
  input  lane_cnt_t  cln_cnt_hs_trail,
  input  lane_cnt_t  cln_cnt_hs_exit,
  output logic       lp_tx_cp_clk,       // LP line P
  output logic       lp_tx_cn_clk,       // LP line N
  output logic       hs_tx_cp_clk,       // HS clock
  output logic       lp_tx_cntrl_clk,    // LP driver enable
  output logic       hs_tx_cntrl_clk,    // HS driver enable
  output logic       ulpsactivenot_clk,
  output logic       stopstate_clk,
  output logic       sot                 // To the data lanes
);

  logic hs_start;                        // LP to HS handover
  logic hs_done;                         // HS to LP, trail over

  // **********************************************************************
  // LP sequencing
  // **********************************************************************
  lp_lane_fsm lp_lane_fsm_i (
    .txddrclkhs_q      (txddrclkhs_q),
    .txddr_q_rst_n     (txddr_q_rst_n),
    .txrequesths_clk   (txrequesths_clk),
    .txulpsclk         (txulpsclk),
    .txulpsexit_clk    (txulpsexit_clk),
    .cln_cnt_lpx       (cln_cnt_lpx),
    .cln_cnt_hs_prep   (cln_cnt_hs_prep),
    .cln_cnt_hs_exit   (cln_cnt_hs_exit),
    .hs_done           (hs_done),
    .lp_tx_cp_clk      (lp_tx_cp_clk),
    .lp_tx_cn_clk      (lp_tx_cn_clk),
    .lp_tx_cntrl_clk   (lp_tx_cntrl_clk),
    .hs_tx_cntrl_clk   (hs_tx_cntrl_clk),
    .stopstate_clk     (stopstate_clk),
    .ulpsactivenot_clk (ulpsactivenot_clk),
    .hs_start          (hs_start)
  );

  // **********************************************************************
  // HS clock generation
  // **********************************************************************
  hs_clk_fsm hs_clk_fsm_i (
    .txddrclkhs_q     (txddrclkhs_q),
    .txddr_q_rst_n    (txddr_q_rst_n),
    .hs_start         (hs_start),
    .txrequesths_clk  (txrequesths_clk),
    .eot              (eot),
    .cln_cnt_hs_zero  (cln_cnt_hs_zero),
    .cln_cnt_hs_trail (cln_cnt_hs_trail),
    .hs_tx_cp_clk     (hs_tx_cp_clk),
    .sot              (sot),
    .hs_done          (hs_done)
  );

endmodule

//--- source/hs_clk_fsm.sv
/* High-speed side of the clock lane: HS-zero, clock toggling, sot,
   post interval after eot and HS-trail */
`timescale 1ns/100ps

module hs_clk_fsm
  import clk_lane_pkg::*;
(
  input  logic       txddrclkhs_q,       // HS quadrature clock
  input  logic       txddr_q_rst_n,      // Sync reset, active high
  input  logic       hs_start,           // LP side has handed over the lane
  input  logic       txrequesths_clk,    // PPI HS clock request
  input  logic       eot,                // End of transmission from the data lanes
  input  lane_cnt_t  cln_cnt_hs_zero,    // HS-zero length
  input  lane_cnt_t  cln_cnt_hs_trail,   // HS-trail length
  output logic       hs_tx_cp_clk,       // HS clock to the transceiver
  output logic       sot,                // Start of transmission to the data lanes
  output logic       hs_done             // End of trail, one cycle
);

  hs_state_e  hs_state;
  hs_state_e  hs_state_nxt;
  logic       timer_start;
  lane_cnt_t  timer_load;
  logic       timer_done;
  logic       eot_q;                     // eot delayed for edge detect
  logic       eot_rise;
  logic       post_armed;                // eot seen, post interval running
  cycle_cnt_t post_cnt;
  logic       post_ok;                   // Post interval over
  cycle_cnt_t pre_cnt;                   // Toggle cycles before sot

  // **********************************************************************
  // HS-zero / trail timer
  // **********************************************************************
  interval_timer hs_timer_i (
    .txddrclkhs_q  (txddrclkhs_q),
    .txddr_q_rst_n (txddr_q_rst_n),
    .timer_start   (timer_start),
    .timer_load    (timer_load),
    .timer_done    (timer_done)
  );

  // **********************************************************************
  // Next state
  // **********************************************************************
  always_comb
  begin
    hs_state_nxt = hs_state;
    timer_start  = 1'b0;
    timer_load   = '0;
    case (hs_state)
      HS_IDLE:
      begin
        if (hs_start)
        begin
          hs_state_nxt = HS_ZERO;
          timer_start  = 1'b1;
          timer_load   = cln_cnt_hs_zero;
        end
      end
      HS_ZERO:
      begin
        if (timer_done)
          hs_state_nxt = HS_TOGGLE;
      end
      HS_TOGGLE:
      begin
        if (post_ok && !txrequesths_clk) // Later of post interval and request low
        begin
          hs_state_nxt = HS_TRAIL;
          timer_start  = 1'b1;
          timer_load   = cln_cnt_hs_trail;
        end
      end
      HS_TRAIL:
      begin
        if (timer_done)
          hs_state_nxt = HS_IDLE;
      end
      default: hs_state_nxt = HS_IDLE;
    endcase
  end

  assign hs_done  = (hs_state == HS_TRAIL) && timer_done;
  assign eot_rise = eot && !eot_q;
  assign post_ok  = post_armed && (post_cnt == '0);

  // **********************************************************************
  // Post interval after rising eot
  // **********************************************************************
  // Loaded two short so post_ok is up in the cycle that decides trail
  always_ff @(posedge txddrclkhs_q)
  begin
    if (txddr_q_rst_n)
    begin
      eot_q      <= 1'b0;
      post_armed <= 1'b0;
      post_cnt   <= '0;
    end
    else
    begin
      eot_q <= eot;
      if (eot_rise)
      begin
        post_armed <= 1'b1;
        post_cnt   <= cycle_cnt_t'(CLK_POST_CYCLES - 2);
      end
      else if (hs_state_nxt == HS_TRAIL)
        post_armed <= 1'b0;              // Used up by this burst
      else if (post_cnt != '0)
        post_cnt <= post_cnt - 1'b1;
    end
  end

  // **********************************************************************
  // State, HS clock and sot
  // **********************************************************************
  always_ff @(posedge txddrclkhs_q)
  begin
    if (txddr_q_rst_n)
    begin
      hs_state     <= HS_IDLE;
      hs_tx_cp_clk <= 1'b0;
      sot          <= 1'b0;
      pre_cnt      <= '0;
    end
    else
    begin
      hs_state     <= hs_state_nxt;
      // First toggle drives a one, zero and trail hold the line low
      hs_tx_cp_clk <= (hs_state_nxt == HS_TOGGLE) ? !hs_tx_cp_clk : 1'b0;
      if (hs_state != HS_TOGGLE)
        pre_cnt <= '0;
      else if (!sot)
        pre_cnt <= pre_cnt + 1'b1;
      sot <= (hs_state_nxt == HS_TOGGLE) &&
             (sot || (hs_state == HS_TOGGLE &&
                      pre_cnt == cycle_cnt_t'(CLK_PRE_CYCLES - 1)));
    end
  end

  // sot only while the clock runs
  a_sot_toggle : assert property (@(posedge txddrclkhs_q) disable iff (txddr_q_rst_n)
    sot |-> (hs_state == HS_TOGGLE))
    else $error("hs_clk_fsm: sot high outside HS_TOGGLE");

endmodule

//--- source/interval_timer.sv
/* Loadable interval timer, scales a lane count by four and
   flags the last cycle of the interval */
`timescale 1ns/100ps

module interval_timer
  import clk_lane_pkg::*;
(
  input  logic       txddrclkhs_q,     // HS quadrature clock
  input  logic       txddr_q_rst_n,    // Sync reset, active high
  input  logic       timer_start,      // One-cycle load strobe
  input  lane_cnt_t  timer_load,       // Interval in lane units
  output logic       timer_done        // Last cycle of the interval
);

  cycle_cnt_t scaled_load;             // Interval length in cycles
  cycle_cnt_t remain_cnt;              // Cycles left, zero when idle

  // Zero load still gives a one-cycle interval
  assign scaled_load = (timer_load == '0) ? cycle_cnt_t'(1)
                                          : cycle_cnt_t'(DDR_CNT_SCALE * timer_load);

  // **********************************************************************
  // Down-counter
  // **********************************************************************
  always_ff @(posedge txddrclkhs_q)
  begin
    if (txddr_q_rst_n)
    begin
      remain_cnt <= '0;
    end
    else if (timer_start)                 // Restart wins over a running count
    begin
      remain_cnt <= scaled_load;
    end
    else if (remain_cnt != '0)
    begin
      remain_cnt <= remain_cnt - 1'b1;
    end
  end

  // Count of one marks the final cycle, so done lands N cycles after start
  assign timer_done = (remain_cnt == cycle_cnt_t'(1));

  // Done is a single-cycle flag unless the owner reloads in that cycle
  a_done_single : assert property (@(posedge txddrclkhs_q) disable iff (txddr_q_rst_n)
    (timer_done && !timer_start) |=> !timer_done)
    else $error("interval_timer: timer_done held for two cycles");

endmodule

//--- source/lp_lane_fsm.sv
/* Low-power side of the clock lane: stop, HS request / prepare / exit
   sequencing and ULPS entry / exit, with the registered LP line drive */
`timescale 1ns/100ps

module lp_lane_fsm
  import clk_lane_pkg::*;
(
  input  logic       txddrclkhs_q,       // HS quadrature clock
  input  logic       txddr_q_rst_n,      // Sync reset, active high
  input  logic       txrequesths_clk,    // PPI HS clock request
  input  logic       txulpsclk,          // PPI ULPS request
  input  logic       txulpsexit_clk,     // PPI ULPS exit
  input  lane_cnt_t  cln_cnt_lpx,        // LP-01 length
  input  lane_cnt_t  cln_cnt_hs_prep,    // LP-00 prepare length
  input  lane_cnt_t  cln_cnt_hs_exit,    // LP-11 length after trail
  input  logic       hs_done,            // End of trail from the HS side
  output logic       lp_tx_cp_clk,       // LP driver, P line
  output logic       lp_tx_cn_clk,       // LP driver, N line
  output logic       lp_tx_cntrl_clk,    // LP driver enable
  output logic       hs_tx_cntrl_clk,    // HS driver enable
  output logic       stopstate_clk,      // Lane in LP-11
  output logic       ulpsactivenot_clk,  // Low while in ULPS
  output logic       hs_start            // HS side may run
);

  lp_state_e  lp_state;
  lp_state_e  lp_state_nxt;
  lp_line_e   line_nxt;                  // Line pair value for the next state
  logic       timer_start;
  lane_cnt_t  timer_load;
  logic       timer_done;

  // **********************************************************************
  // Request / prepare / exit interval timer
  // **********************************************************************
  interval_timer lp_timer_i (
    .txddrclkhs_q  (txddrclkhs_q),
    .txddr_q_rst_n (txddr_q_rst_n),
    .timer_start   (timer_start),
    .timer_load    (timer_load),
    .timer_done    (timer_done)
  );

  // **********************************************************************
  // Next state
  // **********************************************************************
  // Timer is started in the cycle that moves into a timed state
  always_comb
  begin
    lp_state_nxt = lp_state;
    timer_start  = 1'b0;
    timer_load   = '0;
    case (lp_state)
      LP_STOP:
      begin
        if (txrequesths_clk)             // HS request has priority over ULPS
        begin
          lp_state_nxt = LP_HS_RQST;
          timer_start  = 1'b1;
          timer_load   = cln_cnt_lpx;
        end
        else if (txulpsclk)
        begin
          lp_state_nxt = LP_ULPS_RQST;
        end
      end
      LP_HS_RQST:
      begin
        if (timer_done)
        begin
          lp_state_nxt = LP_HS_PRPR;
          timer_start  = 1'b1;
          timer_load   = cln_cnt_hs_prep;
        end
      end
      LP_HS_PRPR:
      begin
        if (timer_done)
          lp_state_nxt = LP_HS_ACTIVE;   // Hand over to the HS side
      end
      LP_HS_ACTIVE:
      begin
        if (hs_done)                     // Trail finished
        begin
          lp_state_nxt = LP_HS_EXIT;
          timer_start  = 1'b1;
          timer_load   = cln_cnt_hs_exit;
        end
      end
      LP_HS_EXIT:
      begin
        if (timer_done)
          lp_state_nxt = LP_STOP;
      end
      LP_ULPS_RQST: lp_state_nxt = LP_ULPS;   // LP-10 for a single cycle
      LP_ULPS:
      begin
        if (txulpsexit_clk || !txulpsclk)
          lp_state_nxt = LP_ULPS_EXIT;
      end
      LP_ULPS_EXIT:
      begin
        if (!txulpsclk)                  // Mark-1 held until the request drops
          lp_state_nxt = LP_STOP;
      end
      default: lp_state_nxt = LP_STOP;
    endcase
  end

  // Line pair per state
  always_comb
  begin
    case (lp_state_nxt)
      LP_HS_RQST:                 line_nxt = LP_01;
      LP_HS_PRPR, LP_HS_ACTIVE:   line_nxt = LP_00;
      LP_ULPS:                    line_nxt = LP_00;
      LP_ULPS_RQST, LP_ULPS_EXIT: line_nxt = LP_10;
      default:                    line_nxt = LP_11;   // Stop and HS exit
    endcase
  end

  // Decoded from the next state so the HS side lines up with hs_tx_cntrl_clk
  assign hs_start = (lp_state_nxt == LP_HS_ACTIVE);

  // **********************************************************************
  // State and output registers
  // **********************************************************************
  always_ff @(posedge txddrclkhs_q)
  begin
    if (txddr_q_rst_n)
    begin
      lp_state          <= LP_STOP;
      lp_tx_cp_clk      <= 1'b1;         // LP-11
      lp_tx_cn_clk      <= 1'b1;
      lp_tx_cntrl_clk   <= 1'b1;
      hs_tx_cntrl_clk   <= 1'b0;
      stopstate_clk     <= 1'b1;
      ulpsactivenot_clk <= 1'b1;
    end
    else
    begin
      lp_state          <= lp_state_nxt;
      {lp_tx_cp_clk, lp_tx_cn_clk} <= line_nxt;
      lp_tx_cntrl_clk   <= (lp_state_nxt != LP_HS_ACTIVE);
      hs_tx_cntrl_clk   <= (lp_state_nxt == LP_HS_ACTIVE);
      stopstate_clk     <= (line_nxt == LP_11);
      ulpsactivenot_clk <= (lp_state_nxt != LP_ULPS);
    end
  end

  // Both drivers must never be enabled together
  a_drv_excl : assert property (@(posedge txddrclkhs_q) disable iff (txddr_q_rst_n)
    !(hs_tx_cntrl_clk && lp_tx_cntrl_clk))
    else $error("lp_lane_fsm: HS and LP drivers enabled together");

  // ULPS only after the LP-10 request cycle
  a_ulps_entry : assert property (@(posedge txddrclkhs_q) disable iff (txddr_q_rst_n)
    (lp_state == LP_ULPS) && ($past(lp_state) != LP_ULPS)
      |-> ($past(lp_state) == LP_ULPS_RQST))
    else $error("lp_lane_fsm: ULPS entered without request");

endmodule

//--- tests/clk_lane_tx_vectors.svh
/* Lane transaction table for the clock-lane testbench,
   HS bursts and ULPS visits with their interval counts */

// Columns: kind, lpx, hs_prep, hs_zero, hs_trail, hs_exit,
//          burst_min, burst_max (eot to request low), ulps_hold (LP-00 cycles)

typedef enum logic {
  ROW_HS,                                // Full HS clock burst
  ROW_ULPS                               // ULPS entry, hold and exit
} row_kind_e;

typedef struct packed {
  row_kind_e kind;
  lane_cnt_t lpx;
  lane_cnt_t hs_prep;
  lane_cnt_t hs_zero;
  lane_cnt_t hs_trail;
  lane_cnt_t hs_exit;
  int        burst_min;                  // Shortest eot to request-low gap
  int        burst_max;                  // Longest gap
  int        ulps_hold;                  // At least 2
} row_t;

localparam int NUM_ROWS = 6;

// **********************************************************************
// Rows
// **********************************************************************
localparam row_t ROW_TABLE [NUM_ROWS] = '{
  // Short burst, post interval decides trail
  '{ROW_HS,   8'd2, 8'd3, 8'd5, 8'd3, 8'd2,  1, 20, 0},
  // Long burst, request low decides trail; zero prep and exit
  '{ROW_HS,   8'd1, 8'd0, 8'd2, 8'd1, 8'd0, 40, 60, 0},
  '{ROW_ULPS, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0,  0,  0, 6},
  // Gap around the post interval
  '{ROW_HS,   8'd3, 8'd2, 8'd4, 8'd2, 8'd3, 25, 45, 0},
  // Zero lpx and trail count as one cycle
  '{ROW_HS,   8'd0, 8'd1, 8'd1, 8'd0, 8'd1,  5, 10, 0},
  '{ROW_ULPS, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0,  0,  0, 2}
};

//--- tests/clk_lane_tx_tb.sv
/* Clock-lane transmitter testbench with clock, reset, table loop,
   port monitors, compare tasks, timeout and summary */
`timescale 1ns/100ps

module clk_lane_tx_tb
  import clk_lane_pkg::*;
();

  `include "clk_lane_tx_vectors.svh"

  localparam int ULPS_EXIT_HOLD = 4;     // LP-10 cycles before txulpsclk drops

  logic       txddrclkhs_q;
  logic       txddr_q_rst_n;
  logic       txrequesths_clk;
  logic       txulpsclk;
  logic       txulpsexit_clk;
  logic       eot;
  lane_cnt_t  cln_cnt_lpx;
  lane_cnt_t  cln_cnt_hs_prep;
  lane_cnt_t  cln_cnt_hs_zero;
  lane_cnt_t  cln_cnt_hs_trail;
  lane_cnt_t  cln_cnt_hs_exit;
  logic       lp_tx_cp_clk;
  logic       lp_tx_cn_clk;
  logic       hs_tx_cp_clk;
  logic       lp_tx_cntrl_clk;
  logic       hs_tx_cntrl_clk;
  logic       ulpsactivenot_clk;
  logic       stopstate_clk;
  logic       sot;

  int err_cnt;
  int chk_cnt;
  int cycle_cnt;
  int cycle_limit;
  int seed;
  int pend_exit;                         // Exit cycles left when the next row starts
  int burst_len [NUM_ROWS];

  clk_lane_tx_top clk_lane_tx_top_i (.*);

  always #10 txddrclkhs_q = ~txddrclkhs_q;   // 20 ns period

  // **********************************************************************
  // Compare tasks
  // **********************************************************************
  task automatic check_line(input string name, input lp_line_e got, input lp_line_e exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input cycle_cnt_t got, input cycle_cnt_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Zero count still lasts one cycle
  function automatic int scaled_len(input lane_cnt_t c);
    return (c == 0) ? 1 : 4 * c;
  endfunction

  function automatic lp_line_e line_now();
    return lp_line_e'({lp_tx_cp_clk, lp_tx_cn_clk});
  endfunction

  function automatic int row_max_cycles(input int r);
    row_t row;
    row = ROW_TABLE[r];
    if (row.kind == ROW_ULPS)
      return row.ulps_hold + ULPS_EXIT_HOLD + 10;
    return scaled_len(row.lpx) + scaled_len(row.hs_prep) + scaled_len(row.hs_zero) +
           scaled_len(row.hs_trail) + scaled_len(row.hs_exit) + CLK_PRE_CYCLES +
           ((row.burst_max + 1 > CLK_POST_CYCLES) ? row.burst_max + 1 : CLK_POST_CYCLES) + 10;
  endfunction

  task automatic print_summary();
    $display("Summary: %0d errors in %0d checks", err_cnt, chk_cnt);
  endtask

  // Counts LP-11 up to the request and any exit cycles left from the row before
  task automatic wait_stop_leave();
    int n;
    n = 0;
    @(negedge txddrclkhs_q);
    while (line_now() == LP_11)
    begin
      check_bit("stopstate_clk", stopstate_clk, 1'b1);
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("lp11_cycles", cycle_cnt_t'(n), cycle_cnt_t'(pend_exit + 1));
  endtask

  // **********************************************************************
  // HS burst row
  // **********************************************************************
  task automatic run_hs(input int r);
    row_t row;
    int   n;
    int   k;
    int   exp_gap;
    logic exp_cp;
    logic done;
    row = ROW_TABLE[r];
    @(posedge txddrclkhs_q);
    cln_cnt_lpx      <= row.lpx;
    cln_cnt_hs_prep  <= row.hs_prep;
    cln_cnt_hs_zero  <= row.hs_zero;
    cln_cnt_hs_trail <= row.hs_trail;
    cln_cnt_hs_exit  <= row.hs_exit;
    txrequesths_clk  <= 1'b1;
    wait_stop_leave();
    check_line("lp_line", line_now(), LP_01);                      // Request
    n = 0;
    while (line_now() == LP_01)
    begin
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("lp01_cycles", cycle_cnt_t'(n), cycle_cnt_t'(scaled_len(row.lpx)));
    check_line("lp_line", line_now(), LP_00);                      // Prepare
    check_bit("lp_tx_cntrl_clk", lp_tx_cntrl_clk, 1'b1);
    n = 0;
    while (line_now() == LP_00 && lp_tx_cntrl_clk)
    begin
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("prep_cycles", cycle_cnt_t'(n), cycle_cnt_t'(scaled_len(row.hs_prep)));
    check_bit("hs_tx_cntrl_clk", hs_tx_cntrl_clk, 1'b1);            // HS-zero
    check_bit("hs_tx_cp_clk", hs_tx_cp_clk, 1'b0);
    n = 0;
    while (hs_tx_cntrl_clk && !hs_tx_cp_clk)
    begin
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("zero_cycles", cycle_cnt_t'(n), cycle_cnt_t'(scaled_len(row.hs_zero)));
    check_bit("hs_tx_cp_clk", hs_tx_cp_clk, 1'b1);                 // First toggle
    n = 0;
    exp_cp = 1'b1;
    while (!sot)
    begin
      n++;
      @(negedge txddrclkhs_q);
      exp_cp = !exp_cp;                                            // One toggle per cycle
      check_bit("hs_tx_cp_clk", hs_tx_cp_clk, exp_cp);
    end
    check_count("pre_cycles", cycle_cnt_t'(n), cycle_cnt_t'(CLK_PRE_CYCLES));
    // One-cycle eot pulse and request low burst_len cycles later
    n = 0;
    k = 0;
    done = 1'b0;
    while (!done)
    begin
      @(posedge txddrclkhs_q);
      if (k == 0)
        eot <= 1'b1;
      if (k == 1)
        eot <= 1'b0;
      if (k == burst_len[r])
        txrequesths_clk <= 1'b0;
      @(negedge txddrclkhs_q);
      if (sot)
      begin
        n++;
        exp_cp = !exp_cp;
        check_bit("hs_tx_cp_clk", hs_tx_cp_clk, exp_cp);
      end
      else
        done = 1'b1;
      k++;
    end
    exp_gap = (burst_len[r] + 1 > CLK_POST_CYCLES) ? burst_len[r] + 1 : CLK_POST_CYCLES;
    check_count("eot_to_trail", cycle_cnt_t'(n), cycle_cnt_t'(exp_gap));
    n = 0;
    while (hs_tx_cntrl_clk && !hs_tx_cp_clk && !sot)               // Trail
    begin
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("trail_cycles", cycle_cnt_t'(n), cycle_cnt_t'(scaled_len(row.hs_trail)));
    check_bit("hs_tx_cntrl_clk", hs_tx_cntrl_clk, 1'b0);            // Exit
    check_bit("lp_tx_cntrl_clk", lp_tx_cntrl_clk, 1'b1);
    check_bit("stopstate_clk", stopstate_clk, 1'b1);
    check_line("lp_line", line_now(), LP_11);
    pend_exit = scaled_len(row.hs_exit) - 1;   // Already one exit cycle seen
  endtask

  // **********************************************************************
  // ULPS row
  // **********************************************************************
  task automatic run_ulps(input int r);
    row_t row;
    int   n;
    int   k;
    logic done;
    row = ROW_TABLE[r];
    @(posedge txddrclkhs_q);
    txulpsclk <= 1'b1;
    wait_stop_leave();
    check_line("lp_line", line_now(), LP_10);                      // Request cycle
    check_bit("ulpsactivenot_clk", ulpsactivenot_clk, 1'b1);
    n = 0;
    while (line_now() == LP_10)
    begin
      n++;
      @(negedge txddrclkhs_q);
    end
    check_count("ulps_rqst_cycles", cycle_cnt_t'(n), cycle_cnt_t'(1));
    check_line("lp_line", line_now(), LP_00);
    check_bit("ulpsactivenot_clk", ulpsactivenot_clk, 1'b0);
    n = 1;
    k = 1;
    done = 1'b0;
    while (!done)                                                   // ULPS hold
    begin
      @(posedge txddrclkhs_q);
      if (k == row.ulps_hold - 1)
        txulpsexit_clk <= 1'b1;
      @(negedge txddrclkhs_q);
      if (line_now() == LP_00 && !ulpsactivenot_clk)
        n++;
      else
        done = 1'b1;
      k++;
    end
    check_count("ulps_cycles", cycle_cnt_t'(n), cycle_cnt_t'(row.ulps_hold));
    check_line("lp_line", line_now(), LP_10);                      // Mark-1
    check_bit("ulpsactivenot_clk", ulpsactivenot_clk, 1'b1);
    n = 1;
    k = 1;
    done = 1'b0;
    while (!done)
    begin
      @(posedge txddrclkhs_q);
      if (k == ULPS_EXIT_HOLD - 1)
      begin
        txulpsclk      <= 1'b0;
        txulpsexit_clk <= 1'b0;
      end
      @(negedge txddrclkhs_q);
      if (line_now() == LP_10)
        n++;
      else
        done = 1'b1;
      k++;
    end
    check_count("ulps_exit_cycles", cycle_cnt_t'(n), cycle_cnt_t'(ULPS_EXIT_HOLD));
    check_line("lp_line", line_now(), LP_11);
    check_bit("stopstate_clk", stopstate_clk, 1'b1);
    pend_exit = 0;
  endtask

  // Driver enables never both high
  always @(negedge txddrclkhs_q)
  begin
    if (!txddr_q_rst_n)
      check_bit("drv_excl", hs_tx_cntrl_clk && lp_tx_cntrl_clk, 1'b0);
  end

  // **********************************************************************
  // Timeout
  // **********************************************************************
  always @(posedge txddrclkhs_q)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: lane did not finish the table within %0d cycles", cycle_limit);
      print_summary();
      $display("Testbench failed");
      $finish;
    end
  end

  // **********************************************************************
  // Main sequence
  // **********************************************************************
  initial
  begin
    txddrclkhs_q     = 1'b0;
    txddr_q_rst_n    = 1'b1;             // Reset asserted
    txrequesths_clk  = 1'b0;
    txulpsclk        = 1'b0;
    txulpsexit_clk   = 1'b0;
    eot              = 1'b0;
    cln_cnt_lpx      = '0;
    cln_cnt_hs_prep  = '0;
    cln_cnt_hs_zero  = '0;
    cln_cnt_hs_trail = '0;
    cln_cnt_hs_exit  = '0;
    err_cnt          = 0;
    chk_cnt          = 0;
    cycle_cnt        = 0;
    pend_exit        = 0;
    seed             = 94226;
    cycle_limit      = 200;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      burst_len[r] = ROW_TABLE[r].burst_min +
                     ($unsigned($random(seed)) %
                      (ROW_TABLE[r].burst_max - ROW_TABLE[r].burst_min + 1));
      cycle_limit += row_max_cycles(r);
    end
    repeat (10) @(posedge txddrclkhs_q);
    txddr_q_rst_n <= 1'b0;
    @(negedge txddrclkhs_q);
    check_line("lp_line", line_now(), LP_11);                      // Reset values
    check_bit("stopstate_clk", stopstate_clk, 1'b1);
    check_bit("lp_tx_cntrl_clk", lp_tx_cntrl_clk, 1'b1);
    check_bit("ulpsactivenot_clk", ulpsactivenot_clk, 1'b1);
    check_bit("hs_tx_cntrl_clk", hs_tx_cntrl_clk, 1'b0);
    check_bit("sot", sot, 1'b0);
    check_bit("hs_tx_cp_clk", hs_tx_cp_clk, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      if (ROW_TABLE[r].kind == ROW_HS)
        run_hs(r);
      else
        run_ulps(r);
    end
    print_summary();
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
